// ==== logic/periph_pkg.sv ====
// ------------------------------------------------
// Shared types and constants of the APB peripheral subsystem.
// Holds the APB request/response structs, the address map
// and the register offsets. Import with periph_pkg::*.
// ------------------------------------------------

package periph_pkg;

   // ------------------------------------------------
   // APB bus
   // ------------------------------------------------
   localparam int unsigned APB_ADDR_W = 32;
   localparam int unsigned APB_DATA_W = 32;

   typedef struct packed {
      logic [APB_ADDR_W-1:0] paddr;
      logic                  psel;
      logic                  penable;
      logic                  pwrite;
      logic [APB_DATA_W-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [APB_DATA_W-1:0] prdata;
      logic                  pready;
      logic                  pslverr;
   } apb_rsp_t;

   // ------------------------------------------------
   // Address map
   // ------------------------------------------------
   localparam logic [APB_ADDR_W-1:0] GPIO_BASE    = 32'h1A10_1000;
   localparam logic [APB_ADDR_W-1:0] SOCCTRL_BASE = 32'h1A10_4000;
   localparam logic [APB_ADDR_W-1:0] PERIPH_SPAN  = 32'h0000_1000;

   // Offset bits that stay inside one 4 KiB window
   localparam int unsigned REG_OFFSET_W = 12;

   typedef enum logic [1:0] {
      SEL_NONE    = 2'd0,
      SEL_GPIO    = 2'd1,
      SEL_SOCCTRL = 2'd2
   } periph_sel_e;

   typedef enum logic [REG_OFFSET_W-1:0] {
      GPIO_DIR = 12'h000,
      GPIO_OUT = 12'h004,
      GPIO_IN  = 12'h008
   } gpio_reg_e;

   typedef enum logic [REG_OFFSET_W-1:0] {
      SC_CTRL            = 12'h000,
      SC_LLC_CACHE_START = 12'h004,
      SC_LLC_CACHE_END   = 12'h008,
      SC_LLC_SPM_START   = 12'h00C,
      SC_RD_HIT          = 12'h010,
      SC_RD_MISS         = 12'h014,
      SC_WR_HIT          = 12'h018,
      SC_WR_MISS         = 12'h01C
   } socctrl_reg_e;

   // One pulse per LLC access outcome
   typedef struct packed {
      logic rd_hit;
      logic rd_miss;
      logic wr_hit;
      logic wr_miss;
   } llc_event_t;

   localparam int unsigned MAX_GPIO = 32;

endpackage

// ==== logic/periph_bus_split.sv ====
// ------------------------------------------------
// Peripheral bus splitter. Routes each APB transfer to the
// GPIO or SoC control block by address window and merges the
// responses. Unmapped addresses complete with an error.
// ------------------------------------------------

`timescale 1ns/1ps

module periph_bus_split
   import periph_pkg::*;
(
   input  apb_req_t apb_req_i,
   output apb_rsp_t apb_rsp_o,

   output apb_req_t gpio_req_o,
   input  apb_rsp_t gpio_rsp_i,

   output apb_req_t socctrl_req_o,
   input  apb_rsp_t socctrl_rsp_i
);

   periph_sel_e sel;

   // True when addr lies in the window starting at base
   function automatic logic in_window(
      input logic [APB_ADDR_W-1:0] addr,
      input logic [APB_ADDR_W-1:0] base
   );
      logic [APB_ADDR_W-1:0] limit;
      limit = base + PERIPH_SPAN;
      return (addr >= base) && (addr < limit);
   endfunction

   // ------------------------------------------------
   // Window decode
   // ------------------------------------------------
   always_comb begin
      if (in_window(apb_req_i.paddr, GPIO_BASE)) begin
         sel = SEL_GPIO;
      end else if (in_window(apb_req_i.paddr, SOCCTRL_BASE)) begin
         sel = SEL_SOCCTRL;
      end else begin
         sel = SEL_NONE;
      end
   end

   // ------------------------------------------------
   // Request fan-out
   // ------------------------------------------------
   // Both targets see the full request, only the selected one sees psel
   always_comb begin
      gpio_req_o         = apb_req_i;
      gpio_req_o.psel    = apb_req_i.psel & (sel == SEL_GPIO);
      socctrl_req_o      = apb_req_i;
      socctrl_req_o.psel = apb_req_i.psel & (sel == SEL_SOCCTRL);
   end

   // ------------------------------------------------
   // Response merge
   // ------------------------------------------------
   always_comb begin
      case (sel)
         SEL_GPIO: begin
            apb_rsp_o = gpio_rsp_i;
         end
         SEL_SOCCTRL: begin
            apb_rsp_o = socctrl_rsp_i;
         end
         default: begin
            // Nobody owns this address, finish at once with an error
            apb_rsp_o.prdata  = '0;
            apb_rsp_o.pready  = 1'b1;
            apb_rsp_o.pslverr = apb_req_i.psel;
         end
      endcase
   end

endmodule

// ==== logic/gpio_regs.sv ====
// ------------------------------------------------
// GPIO register block on APB. Direction and output registers
// drive the pins, inputs are synchronized and readable.
// Zero-wait target, NUM_GPIO up to MAX_GPIO pins.
// ------------------------------------------------

`timescale 1ns/1ps

module gpio_regs
   import periph_pkg::*;
#(
   parameter int unsigned NUM_GPIO = 32
) (
   input  logic                clk_i,
   input  logic                reset_i,

   input  apb_req_t            apb_req_i,
   output apb_rsp_t            apb_rsp_o,

   input  logic [NUM_GPIO-1:0] gpio_in_i,
   output logic [NUM_GPIO-1:0] gpio_out_o,
   output logic [NUM_GPIO-1:0] gpio_oe_o
);

   logic [NUM_GPIO-1:0] dir_q;
   logic [NUM_GPIO-1:0] out_q;
   logic [NUM_GPIO-1:0] sync_q;
   logic [NUM_GPIO-1:0] in_q;

   gpio_reg_e             reg_sel;
   logic                  wr_en;
   logic                  dir_we;
   logic                  out_we;
   logic                  err;
   logic [APB_DATA_W-1:0] rdata;

   // Zero-extend a pin vector to a bus word, unused bits read as 0
   function automatic logic [APB_DATA_W-1:0] widen(input logic [NUM_GPIO-1:0] val);
      logic [MAX_GPIO-1:0] ext;
      ext               = '0;
      ext[NUM_GPIO-1:0] = val;
      return APB_DATA_W'(ext);
   endfunction

   assign reg_sel = gpio_reg_e'(apb_req_i.paddr[REG_OFFSET_W-1:0]);
   assign wr_en   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

   // ------------------------------------------------
   // Register decode
   // ------------------------------------------------
   always_comb begin
      rdata  = '0;
      err    = 1'b0;
      dir_we = 1'b0;
      out_we = 1'b0;
      case (reg_sel)
         GPIO_DIR: begin
            rdata  = widen(dir_q);
            dir_we = wr_en;
         end
         GPIO_OUT: begin
            rdata  = widen(out_q);
            out_we = wr_en;
         end
         GPIO_IN: begin
            // Input register is read only
            if (apb_req_i.pwrite) begin
               err = 1'b1;
            end else begin
               rdata = widen(in_q);
            end
         end
         default: begin
            err = 1'b1;
         end
      endcase
   end

   assign apb_rsp_o.prdata  = apb_req_i.psel ? rdata : '0;
   assign apb_rsp_o.pready  = 1'b1;
   assign apb_rsp_o.pslverr = apb_req_i.psel & err;

   // ------------------------------------------------
   // Registers and input synchronizer
   // ------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         dir_q  <= '0;
         out_q  <= '0;
         sync_q <= '0;
         in_q   <= '0;
      end else begin
         if (dir_we) begin
            dir_q <= apb_req_i.pwdata[NUM_GPIO-1:0];
         end
         if (out_we) begin
            out_q <= apb_req_i.pwdata[NUM_GPIO-1:0];
         end
         // Two flops between the pins and the readable value
         sync_q <= gpio_in_i;
         in_q   <= sync_q;
      end
   end

   assign gpio_out_o = out_q;
   assign gpio_oe_o  = dir_q;

endmodule

// ==== logic/soc_control_regs.sv ====
// ------------------------------------------------
// SoC control register block on APB. Cluster boot control,
// LLC address windows and LLC hit/miss event counters.
// Zero-wait target, counters clear on any write.
// ------------------------------------------------

`timescale 1ns/1ps

module soc_control_regs
   import periph_pkg::*;
(
   input  logic        clk_i,
   input  logic        reset_i,

   input  apb_req_t    apb_req_i,
   output apb_rsp_t    apb_rsp_o,

   input  llc_event_t  llc_event_i,

   output logic        cluster_fetch_en_o,
   output logic        cluster_en_sa_boot_o,
   output logic [31:0] llc_cache_addr_start_o,
   output logic [31:0] llc_cache_addr_end_o,
   output logic [31:0] llc_spm_addr_start_o
);

   localparam int unsigned NUM_WIN = 3;
   localparam int unsigned NUM_CNT = 4;

   // Control bits, bit 0 fetch enable and bit 1 standalone boot
   logic [1:0] ctrl_q;

   // Window 0 cache start, 1 cache end, 2 SPM start
   logic [NUM_WIN-1:0][APB_DATA_W-1:0] win_q;

   // Counter 0 read hit, 1 read miss, 2 write hit, 3 write miss
   logic [NUM_CNT-1:0][APB_DATA_W-1:0] cnt_q;
   logic [NUM_CNT-1:0]                 cnt_ev;

   socctrl_reg_e          reg_sel;
   logic                  wr_en;
   logic                  ctrl_we;
   logic [NUM_WIN-1:0]    win_we;
   logic [NUM_CNT-1:0]    cnt_clr;
   logic                  err;
   logic [APB_DATA_W-1:0] rdata;

   assign reg_sel = socctrl_reg_e'(apb_req_i.paddr[REG_OFFSET_W-1:0]);
   assign wr_en   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

   assign cnt_ev[0] = llc_event_i.rd_hit;
   assign cnt_ev[1] = llc_event_i.rd_miss;
   assign cnt_ev[2] = llc_event_i.wr_hit;
   assign cnt_ev[3] = llc_event_i.wr_miss;

   // ------------------------------------------------
   // Register decode
   // ------------------------------------------------
   always_comb begin
      rdata   = '0;
      err     = 1'b0;
      ctrl_we = 1'b0;
      win_we  = '0;
      cnt_clr = '0;
      case (reg_sel)
         SC_CTRL: begin
            rdata   = {{(APB_DATA_W-2){1'b0}}, ctrl_q};
            ctrl_we = wr_en;
         end
         SC_LLC_CACHE_START: begin
            rdata     = win_q[0];
            win_we[0] = wr_en;
         end
         SC_LLC_CACHE_END: begin
            rdata     = win_q[1];
            win_we[1] = wr_en;
         end
         SC_LLC_SPM_START: begin
            rdata     = win_q[2];
            win_we[2] = wr_en;
         end
         SC_RD_HIT: begin
            rdata      = cnt_q[0];
            cnt_clr[0] = wr_en;
         end
         SC_RD_MISS: begin
            rdata      = cnt_q[1];
            cnt_clr[1] = wr_en;
         end
         SC_WR_HIT: begin
            rdata      = cnt_q[2];
            cnt_clr[2] = wr_en;
         end
         SC_WR_MISS: begin
            rdata      = cnt_q[3];
            cnt_clr[3] = wr_en;
         end
         default: begin
            err = 1'b1;
         end
      endcase
   end

   assign apb_rsp_o.prdata  = apb_req_i.psel ? rdata : '0;
   assign apb_rsp_o.pready  = 1'b1;
   assign apb_rsp_o.pslverr = apb_req_i.psel & err;

   // ------------------------------------------------
   // Control and window registers
   // ------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ctrl_q <= '0;
         win_q  <= '0;
      end else begin
         if (ctrl_we) begin
            ctrl_q <= apb_req_i.pwdata[1:0];
         end
         for (int i = 0; i < NUM_WIN; i++) begin
            if (win_we[i]) begin
               win_q[i] <= apb_req_i.pwdata;
            end
         end
      end
   end

   // ------------------------------------------------
   // Event counters
   // ------------------------------------------------
   // Clear has priority over a same-cycle event, counters wrap
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         cnt_q <= '0;
      end else begin
         for (int i = 0; i < NUM_CNT; i++) begin
            if (cnt_clr[i]) begin
               cnt_q[i] <= '0;
            end else if (cnt_ev[i]) begin
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
      end
   end

   assign cluster_fetch_en_o     = ctrl_q[0];
   assign cluster_en_sa_boot_o   = ctrl_q[1];
   assign llc_cache_addr_start_o = win_q[0];
   assign llc_cache_addr_end_o   = win_q[1];
   assign llc_spm_addr_start_o   = win_q[2];

endmodule

// ==== logic/apb_periph_subsystem.sv ====
// ------------------------------------------------
// Top level of the APB peripheral subsystem. One APB slave
// port, split into the GPIO and SoC control register blocks.
// ------------------------------------------------

`timescale 1ns/1ps

module apb_periph_subsystem
   import periph_pkg::*;
#(
   parameter int unsigned NUM_GPIO = 32
) (
   input  logic                clk_i,
   input  logic                reset_i,

   input  apb_req_t            apb_req_i,
   output apb_rsp_t            apb_rsp_o,

   input  logic [NUM_GPIO-1:0] gpio_in_i,
   output logic [NUM_GPIO-1:0] gpio_out_o,
   output logic [NUM_GPIO-1:0] gpio_oe_o,

   input  llc_event_t          llc_event_i,

   output logic                cluster_fetch_en_o,
   output logic                cluster_en_sa_boot_o,
   output logic [31:0]         llc_cache_addr_start_o,
   output logic [31:0]         llc_cache_addr_end_o,
   output logic [31:0]         llc_spm_addr_start_o
);

   apb_req_t gpio_req;
   apb_rsp_t gpio_rsp;
   apb_req_t socctrl_req;
   apb_rsp_t socctrl_rsp;

   periph_bus_split i_periph_bus_split (
      .apb_req_i     ( apb_req_i   ),
      .apb_rsp_o     ( apb_rsp_o   ),
      .gpio_req_o    ( gpio_req    ),
      .gpio_rsp_i    ( gpio_rsp    ),
      .socctrl_req_o ( socctrl_req ),
      .socctrl_rsp_i ( socctrl_rsp )
   );

   gpio_regs #(
      .NUM_GPIO ( NUM_GPIO )
   ) i_gpio_regs (
      .clk_i      ( clk_i      ),
      .reset_i    ( reset_i    ),
      .apb_req_i  ( gpio_req   ),
      .apb_rsp_o  ( gpio_rsp   ),
      .gpio_in_i  ( gpio_in_i  ),
      .gpio_out_o ( gpio_out_o ),
      .gpio_oe_o  ( gpio_oe_o  )
   );

   soc_control_regs i_soc_control_regs (
      .clk_i                  ( clk_i                  ),
      .reset_i                ( reset_i                ),
      .apb_req_i              ( socctrl_req            ),
      .apb_rsp_o              ( socctrl_rsp            ),
      .llc_event_i            ( llc_event_i            ),
      .cluster_fetch_en_o     ( cluster_fetch_en_o     ),
      .cluster_en_sa_boot_o   ( cluster_en_sa_boot_o   ),
      .llc_cache_addr_start_o ( llc_cache_addr_start_o ),
      .llc_cache_addr_end_o   ( llc_cache_addr_end_o   ),
      .llc_spm_addr_start_o   ( llc_spm_addr_start_o   )
   );

endmodule

// ==== bench/tb_apb_periph_subsystem.sv ====
// --------------------------------------------------
// Self-checking testbench for the APB peripheral subsystem.
// Replays bench/periph_stimulus.txt as the APB master, drives
// the GPIO pins and LLC events and checks every response.
// --------------------------------------------------

`timescale 1ns/1ps

module tb_apb_periph_subsystem
   import periph_pkg::*;
();

   localparam int unsigned NUM_GPIO     = 32;
   localparam int unsigned CLK_PERIOD   = 4;
   localparam int unsigned DRIVE_DLY    = 1;
   localparam int unsigned RESET_CYCLES = 8;
   localparam int unsigned READY_LIMIT  = 16;
   localparam string       STIM_FILE    = "bench/periph_stimulus.txt";

   logic                clk;
   logic                reset;
   apb_req_t            apb_req;
   apb_rsp_t            apb_rsp;
   logic [NUM_GPIO-1:0] gpio_in;
   logic [NUM_GPIO-1:0] gpio_out;
   logic [NUM_GPIO-1:0] gpio_oe;
   llc_event_t          llc_event;
   logic                fetch_en;
   logic                sa_boot;
   logic [31:0]         cache_start;
   logic [31:0]         cache_end;
   logic [31:0]         spm_start;

   int seed        = 10560;
   int line_count  = 0;
   bit count_ready = 1'b0;
   int tests       = 0;
   int checks      = 0;
   int errors      = 0;
   int test_errors = 0;

   apb_periph_subsystem #(
      .NUM_GPIO ( NUM_GPIO )
   ) dut_i (
      .clk_i                  ( clk         ),
      .reset_i                ( reset       ),
      .apb_req_i              ( apb_req     ),
      .apb_rsp_o              ( apb_rsp     ),
      .gpio_in_i              ( gpio_in     ),
      .gpio_out_o             ( gpio_out    ),
      .gpio_oe_o              ( gpio_oe     ),
      .llc_event_i            ( llc_event   ),
      .cluster_fetch_en_o     ( fetch_en    ),
      .cluster_en_sa_boot_o   ( sa_boot     ),
      .llc_cache_addr_start_o ( cache_start ),
      .llc_cache_addr_end_o   ( cache_end   ),
      .llc_spm_addr_start_o   ( spm_start   )
   );

   initial begin : clock_gen
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // --------------------------------------------------
   // Helpers
   // --------------------------------------------------
   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("FAIL %0d ns: %0s got %08h expected %08h", $time, what, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   // A stimulus line that is missing fields cannot be replayed
   task automatic report_bad_line(input logic [7:0] op);
      $display("Error: stimulus line '%c' is missing fields", op);
      errors++;
      test_errors++;
   endtask

   // Called at the drive point, returns at the drive point after the transfer
   task automatic apb_transfer(input logic write, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
      int waits;
      waits           = 0;
      apb_req.paddr   = addr;
      apb_req.pwrite  = write;
      apb_req.pwdata  = wdata;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      @(posedge clk);
      #(DRIVE_DLY);
      apb_req.penable = 1'b1;
      #(DRIVE_DLY);
      while (!apb_rsp.pready && waits < READY_LIMIT) begin
         @(posedge clk);
         #(2 * DRIVE_DLY);
         waits++;
      end
      if (!apb_rsp.pready) begin
         $display("Error: no pready within %0d cycles at address %08h", READY_LIMIT, addr);
         errors++;
         test_errors++;
      end
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge clk);
      #(DRIVE_DLY);
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
   endtask

   task automatic idle_gap();
      int gap;
      gap = $random(seed) & 3;
      repeat (gap) begin
         @(posedge clk);
         #(DRIVE_DLY);
      end
   endtask

   // Output index as listed in the stimulus file header
   function automatic logic [31:0] output_value(input int idx);
      case (idx)
         0: return gpio_out;
         1: return gpio_oe;
         2: return {31'b0, fetch_en};
         3: return {31'b0, sa_boot};
         4: return cache_start;
         5: return cache_end;
         6: return spm_start;
         default: return 32'hDEAD_BEEF;
      endcase
   endfunction

   // Output driven directly by the register at addr, -1 if there is none
   function automatic int mirror_index(input logic [31:0] addr);
      case (addr)
         GPIO_BASE + 32'(GPIO_OUT):              return 0;
         GPIO_BASE + 32'(GPIO_DIR):              return 1;
         SOCCTRL_BASE + 32'(SC_LLC_CACHE_START): return 4;
         SOCCTRL_BASE + 32'(SC_LLC_CACHE_END):   return 5;
         SOCCTRL_BASE + 32'(SC_LLC_SPM_START):   return 6;
         default:                                return -1;
      endcase
   endfunction

   // --------------------------------------------------
   // Stimulus replay
   // --------------------------------------------------
   initial begin : run
      int              fd;
      int              n;
      int              k;
      logic [7:0]      op;
      logic [31:0]     a;
      logic [31:0]     d;
      logic [31:0]     e;
      logic [31:0]     rdata;
      logic            err;
      logic [8*32-1:0] name;
      logic [8*128-1:0] line_buf;
      reset     = 1'b1;
      apb_req   = '0;
      gpio_in   = '0;
      llc_event = '0;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("Error: cannot open stimulus file %0s", STIM_FILE);
         $display("TB FAILED");
      end else begin
         while ($fgets(line_buf, fd) != 0) begin
            line_count++;
         end
         $fclose(fd);
         fd          = $fopen(STIM_FILE, "r");
         count_ready = 1'b1;
         repeat (RESET_CYCLES) @(posedge clk);
         #(DRIVE_DLY);
         reset = 1'b0;
         // Every pin and control output leaves reset at 0
         for (int i = 0; i <= 6; i++) begin
            check_value($sformatf("output %0d after reset", i), output_value(i), '0);
         end
         while ($fscanf(fd, " %c", op) == 1) begin
            case (op)
               "#": n = $fgets(line_buf, fd);
               "W": begin
                  n = $fscanf(fd, " %h %h %h", a, d, e);
                  if (n != 3) report_bad_line(op);
                  apb_transfer(1'b1, a, d, rdata, err);
                  check_value($sformatf("write %08h pslverr", a), {31'b0, err}, e);
               end
               "R": begin
                  n = $fscanf(fd, " %h %h %h", a, d, e);
                  if (n != 3) report_bad_line(op);
                  apb_transfer(1'b0, a, '0, rdata, err);
                  check_value($sformatf("read %08h prdata", a), rdata, d);
                  check_value($sformatf("read %08h pslverr", a), {31'b0, err}, e);
                  // A register that drives a pin output must show the same value there
                  k = mirror_index(a);
                  if (k >= 0 && e == 0) begin
                     check_value($sformatf("output %0d after read %08h", k, a),
                                 output_value(k), d);
                  end
               end
               "P": begin
                  n = $fscanf(fd, " %h", d);
                  if (n != 1) report_bad_line(op);
                  gpio_in = d;
                  repeat (4) @(posedge clk);
                  #(DRIVE_DLY);
               end
               "E": begin
                  n = $fscanf(fd, " %h %d", d, k);
                  if (n != 2) report_bad_line(op);
                  llc_event = llc_event_t'(d[3:0]);
                  repeat (k) @(posedge clk);
                  #(DRIVE_DLY);
                  llc_event = '0;
               end
               "O": begin
                  n = $fscanf(fd, " %d %h", k, d);
                  if (n != 2) report_bad_line(op);
                  check_value($sformatf("output %0d", k), output_value(k), d);
               end
               "T": begin
                  n = $fscanf(fd, " %s", name);
                  if (n != 1) report_bad_line(op);
                  $display("Test %0s finished with %0d errors", name, test_errors);
                  tests++;
                  test_errors = 0;
               end
               default: begin
                  $display("Error: unknown opcode '%c' in stimulus file", op);
                  errors++;
               end
            endcase
            if (op != "#" && op != "T") begin
               idle_gap();
            end
         end
         $fclose(fd);
         $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
         if (errors == 0) begin
            $display("TB PASSED");
         end else begin
            $display("TB FAILED");
         end
      end
      $finish;
   end

   // Budget of 20 cycles per stimulus line on top of reset
   initial begin : watchdog
      wait (count_ready);
      repeat (line_count * 20 + RESET_CYCLES) @(posedge clk);
      $display("Timeout: stimulus did not finish within %0d cycles",
               line_count * 20 + RESET_CYCLES);
      $display("TB FAILED");
      $finish;
   end

endmodule

// ==== bench/periph_stimulus.txt ====
# W addr data err | R addr data err | P pins | E mask cycles | O output value | T name
# E mask bits 3..0 = rd_hit rd_miss wr_hit wr_miss; O 0 gpio_out 1 gpio_oe 2 fetch 3 sa_boot 4..6 llc
R 1A101000 00000000 0
R 1A101004 00000000 0
R 1A104000 00000000 0
R 1A104004 00000000 0
R 1A104008 00000000 0
R 1A10400C 00000000 0
R 1A104010 00000000 0
R 1A10401C 00000000 0
O 0 00000000
O 2 00000000
T reset_values
W 1A101000 0000FF0F 0
W 1A101004 12345678 0
R 1A101000 0000FF0F 0
O 1 0000FF0F
O 0 12345678
P CAFE0001
R 1A101008 CAFE0001 0
W 1A101008 FFFFFFFF 1
T gpio_path
W 1A104000 00000001 0
O 2 00000001
W 1A104000 FFFFFFFF 0
R 1A104000 00000003 0
O 3 00000001
W 1A104004 80000000 0
W 1A104008 80FFFFFF 0
W 1A10400C 81000000 0
R 1A104008 80FFFFFF 0
O 4 80000000
O 6 81000000
T soc_control
E A 5
E 6 3
E 9 2
R 1A104010 00000007 0
R 1A104014 00000003 0
R 1A104018 00000008 0
R 1A10401C 00000002 0
W 1A104010 00000000 0
R 1A104010 00000000 0
T llc_counters
R 1A102000 00000000 1
W 1A100FFC 12345678 1
R 1A101010 00000000 1
W 1A104020 FFFFFFFF 1
R 1A101004 12345678 0
R 1A104004 80000000 0
R 1A104018 00000008 0
T address_errors

// ==== filelist.f ====
logic/periph_pkg.sv
logic/periph_bus_split.sv
logic/gpio_regs.sv
logic/soc_control_regs.sv
logic/apb_periph_subsystem.sv
bench/tb_apb_periph_subsystem.sv

// ==== Makefile ====
# Verilator build and run for the APB peripheral subsystem

TOP             ?= tb_apb_periph_subsystem
SIM_DIR         ?= sim_build
LOG             ?= $(SIM_DIR)/sim.log
FILELIST        ?= filelist.f
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(SIM_DIR) -o V$(TOP)
	$(SIM_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(SIM_DIR)
